// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ahb_cache
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only if the simulation printed the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
hw/cache_pkg.sv
hw/ahb_req_capture.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/line_fill_master.sv
hw/cache_ctrl.sv
hw/ahb_cache_top.sv
dv/ahb_mem_model.sv
dv/tb_ahb_cache.sv

// ==== dv/ahb_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_model #(
    parameter logic [31:0] FILL_KEY = 32'h3c96_a55a,
    parameter logic [31:0] SEED     = 32'h4de1_b8c6
) (
    input  wire         upstream_intf,
    input  wire         rst_n,
    input  wire  [31:0] haddr,
    input  wire  [1:0]  htrans,
    input  wire         hwrite,
    input  wire  [31:0] hwdata,
    output logic [31:0] hrdata,
    output logic        hready
);

    // only written words are stored and the rest follow the fill pattern
    logic [31:0] mem [logic [31:0]];
    logic [31:0] dph_addr;
    logic        dph_write;
    logic        busy;
    logic [1:0]  waits;
    integer      seed = SEED;

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : (addr ^ FILL_KEY);
    endfunction

    always @(posedge upstream_intf or negedge rst_n) begin : slave_seq
        logic [1:0] pick;
        if (!rst_n) begin
            busy   <= 1'b0;
            hready <= 1'b1;
            waits  <= '0;
        end else begin
            if (busy && hready) begin
                // data phase ends on this edge
                if (dph_write) begin
                    mem[dph_addr] = hwdata;
                end
                busy <= 1'b0;
            end else if (busy) begin
                if (waits == 2'd0) begin
                    hready <= 1'b1;
                    hrdata <= word_at(dph_addr);
                end else begin
                    waits <= waits - 2'd1;
                end
            end
            if (hready && htrans[1]) begin
                // 0 to 3 wait states for this beat
                pick = 2'($random(seed));
                busy      <= 1'b1;
                dph_addr  <= {haddr[31:2], 2'b00};
                dph_write <= hwrite;
                if (pick == 2'd0) begin
                    hrdata <= word_at({haddr[31:2], 2'b00});
                end else begin
                    hready <= 1'b0;
                    waits  <= pick - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/tb_ahb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_cache;

    localparam int          CACHE_SIZE = 256;
    localparam int          LINES      = CACHE_SIZE / 16;
    localparam int          INDEX_W    = $clog2(LINES);
    localparam logic [31:0] FILL_KEY   = 32'h3c96_a55a;
    localparam logic [31:0] SEED       = 32'h4de1_b8c6;
    localparam int          N_RANDOM   = 40;
    localparam int          N_PLANNED  = N_RANDOM + 13;
    localparam int          TIMEOUT_NS = (N_PLANNED * 200 + 100) * 8;
    localparam logic [1:0]  TR_IDLE    = 2'b00;
    localparam logic [1:0]  TR_NONSEQ  = 2'b10;
    localparam logic [1:0]  TR_SEQ     = 2'b11;
    localparam logic [2:0]  BU_SINGLE  = 3'b000;
    localparam logic [2:0]  BU_WRAP4   = 3'b010;

    logic        upstream_intf = 1'b0;
    logic        rst_n;
    logic        up_hsel;
    logic [31:0] up_haddr;
    logic [1:0]  up_htrans;
    logic        up_hwrite;
    logic [31:0] up_hwdata;
    wire  [31:0] up_hrdata;
    wire         up_hreadyout;
    wire  [31:0] dn_haddr;
    wire  [1:0]  dn_htrans;
    wire  [2:0]  dn_hburst;
    wire         dn_hwrite;
    wire  [31:0] dn_hwdata;
    wire  [31:0] dn_hrdata;
    wire         dn_hready;
    // single slave on the bus
    wire         up_hready = up_hreadyout;

    logic [31:0] shadow [logic [31:0]];
    logic        exp_valid [LINES];
    logic [31:0] exp_tag [LINES];
    logic [31:0] dn_addr_q [$];
    logic [1:0]  dn_trans_q [$];
    logic [2:0]  dn_burst_q [$];
    logic        dn_write_q [$];
    logic [31:0] dn_wdata_q [$];
    int          errors = 0;
    int          transfers = 0;
    integer      seed = SEED;
    logic        wr_dph;
    logic        prev_stall;
    logic [31:0] prev_haddr;
    logic [1:0]  prev_htrans;

    always #4 upstream_intf = ~upstream_intf;

    ahb_cache_top #(
        .CACHE_SIZE (CACHE_SIZE)
    ) u_dut (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .up_hsel       (up_hsel),
        .up_haddr      (up_haddr),
        .up_htrans     (up_htrans),
        .up_hwrite     (up_hwrite),
        .up_hwdata     (up_hwdata),
        .up_hready     (up_hready),
        .up_hrdata     (up_hrdata),
        .up_hreadyout  (up_hreadyout),
        .dn_haddr      (dn_haddr),
        .dn_htrans     (dn_htrans),
        .dn_hburst     (dn_hburst),
        .dn_hwrite     (dn_hwrite),
        .dn_hwdata     (dn_hwdata),
        .dn_hrdata     (dn_hrdata),
        .dn_hready     (dn_hready)
    );

    ahb_mem_model #(
        .FILL_KEY (FILL_KEY),
        .SEED     (SEED)
    ) u_mem (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (dn_haddr),
        .htrans        (dn_htrans),
        .hwrite        (dn_hwrite),
        .hwdata        (dn_hwdata),
        .hrdata        (dn_hrdata),
        .hready        (dn_hready)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return shadow.exists(addr) ? shadow[addr] : (addr ^ FILL_KEY);
    endfunction

    function automatic int line_index(input logic [31:0] addr);
        return int'((addr >> 4) % LINES);
    endfunction

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic clear_queues();
        dn_addr_q.delete();
        dn_trans_q.delete();
        dn_burst_q.delete();
        dn_write_q.delete();
        dn_wdata_q.delete();
    endtask

    // downstream monitor sees the values of the cycle that ends here
    always @(posedge upstream_intf) begin
        if (!rst_n) begin
            wr_dph     <= 1'b0;
            prev_stall <= 1'b0;
        end else begin
            if (prev_stall) begin
                assert (dn_haddr == prev_haddr && dn_htrans == prev_htrans)
                    else report_error($sformatf("dn bus moved in a wait state, %h", dn_haddr));
            end
            if (wr_dph && dn_hready) begin
                dn_wdata_q.push_back(dn_hwdata);
            end
            if (dn_hready) begin
                wr_dph <= (dn_htrans != TR_IDLE) && dn_hwrite;
            end
            if (dn_htrans != TR_IDLE && dn_hready) begin
                dn_addr_q.push_back(dn_haddr);
                dn_trans_q.push_back(dn_htrans);
                dn_burst_q.push_back(dn_hburst);
                dn_write_q.push_back(dn_hwrite);
            end
            prev_stall  <= !dn_hready;
            prev_haddr  <= dn_haddr;
            prev_htrans <= dn_htrans;
        end
    end

    // starts on a falling edge with up_hready high and ends where the data phase completes
    task automatic run_transfer(input logic [31:0] addr, input logic write,
                                input logic [31:0] wdata, output int waits,
                                output logic [31:0] rdata);
        up_hsel   = 1'b1;
        up_haddr  = addr;
        up_htrans = TR_NONSEQ;
        up_hwrite = write;
        @(negedge upstream_intf);
        up_hsel   = 1'b0;
        up_htrans = TR_IDLE;
        up_hwdata = write ? wdata : 32'h0;
        waits = 0;
        while (!up_hreadyout) begin
            waits++;
            @(negedge upstream_intf);
        end
        rdata = up_hrdata;
        transfers++;
    endtask

    task automatic read_check(input logic [31:0] addr);
        int          idx;
        int          i;
        int          waits;
        logic        hit;
        logic [31:0] rdata;
        logic [31:0] exp_addr;
        idx = line_index(addr);
        hit = exp_valid[idx] && exp_tag[idx] == (addr >> (4 + INDEX_W));
        clear_queues();
        run_transfer(addr, 1'b0, 32'h0, waits, rdata);
        assert (rdata == mem_word(addr))
            else report_error($sformatf("read %h gave %h, expected %h",
                                        addr, rdata, mem_word(addr)));
        if (hit) begin
            // a fill started by the lookup would show its NONSEQ in the next cycle
            @(negedge upstream_intf);
            assert (waits == 0 && dn_addr_q.size() == 0 && dn_htrans == TR_IDLE)
                else report_error($sformatf("hit on %h waited or used the dn bus", addr));
        end else begin
            assert (waits > 0 && dn_addr_q.size() == 4)
                else report_error($sformatf("miss on %h gave %0d dn beats",
                                            addr, dn_addr_q.size()));
            for (i = 0; i < dn_addr_q.size(); i++) begin
                // critical word first, then wrap inside the line
                exp_addr = {addr[31:4], addr[3:2] + i[1:0], 2'b00};
                assert (dn_addr_q[i] == exp_addr && !dn_write_q[i]
                        && dn_burst_q[i] == BU_WRAP4
                        && dn_trans_q[i] == ((i == 0) ? TR_NONSEQ : TR_SEQ))
                    else report_error($sformatf("fill beat %0d at %h, expected %h",
                                                i, dn_addr_q[i], exp_addr));
            end
            exp_valid[idx] = 1'b1;
            exp_tag[idx]   = addr >> (4 + INDEX_W);
        end
    endtask

    task automatic write_check(input logic [31:0] addr, input logic [31:0] data);
        int          idx;
        int          waits;
        logic        hit;
        logic [31:0] rdata;
        idx = line_index(addr);
        hit = exp_valid[idx] && exp_tag[idx] == (addr >> (4 + INDEX_W));
        clear_queues();
        run_transfer(addr, 1'b1, data, waits, rdata);
        assert (waits > 0 && dn_addr_q.size() == 1 && dn_wdata_q.size() == 1)
            else report_error($sformatf("write %h gave %0d dn writes", addr, dn_addr_q.size()));
        if (dn_addr_q.size() == 1 && dn_wdata_q.size() == 1) begin
            assert (dn_addr_q[0] == addr && dn_trans_q[0] == TR_NONSEQ
                    && dn_burst_q[0] == BU_SINGLE && dn_write_q[0] && dn_wdata_q[0] == data)
                else report_error($sformatf("dn write %h = %h, expected %h = %h",
                                            dn_addr_q[0], dn_wdata_q[0], addr, data));
        end
        shadow[addr] = data;
        if (hit) begin
            exp_valid[idx] = 1'b0;
        end
    endtask

    task automatic apply_reset(input int cycles);
        int i;
        rst_n = 1'b0;
        for (i = 0; i < cycles; i++) begin
            @(negedge upstream_intf);
        end
        assert (up_hreadyout && dn_htrans == TR_IDLE)
            else report_error("bus outputs not idle in reset");
        rst_n = 1'b1;
        for (i = 0; i < LINES; i++) begin
            exp_valid[i] = 1'b0;
        end
    endtask

    initial begin
        int          i;
        logic [31:0] rnd;
        logic [31:0] addr;
        up_hsel   = 1'b0;
        up_haddr  = 32'h0;
        up_htrans = TR_IDLE;
        up_hwrite = 1'b0;
        up_hwdata = 32'h0;
        apply_reset(4);
        // cold miss with the critical word mid-line
        read_check(32'h0000_1008);
        read_check(32'h0000_1000);
        read_check(32'h0000_1004);
        read_check(32'h0000_100c);
        // same index with another tag
        read_check(32'h0000_2008);
        read_check(32'h0000_1008);
        write_check(32'h0000_1004, 32'hcafe_0001);
        read_check(32'h0000_1004);
        read_check(32'h0000_1000);
        // a write miss does not allocate
        write_check(32'h0000_3050, 32'h1234_5678);
        read_check(32'h0000_3050);
        read_check(32'h0000_3054);
        apply_reset(4);
        read_check(32'h0000_3054);
        // four tags share each index here
        for (i = 0; i < N_RANDOM; i++) begin
            rnd  = $random(seed);
            addr = {20'h00001, 2'b00, rnd[9:2], 2'b00};
            if (rnd[31:30] == 2'b00) begin
                write_check(addr, $random(seed));
            end else begin
                read_check(addr);
            end
        end
        $display("transfers %0d, errors %0d", transfers, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired, the run hung after %0d transfers", transfers);
        $display("transfers %0d, errors %0d", transfers, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/ahb_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_cache_top #(
    parameter int CACHE_SIZE = 8192
) (
    input  wire                upstream_intf,
    input  wire                rst_n,
    input  wire                up_hsel,
    input  wire cache_pkg::addr_t   up_haddr,
    input  wire cache_pkg::htrans_t up_htrans,
    input  wire                up_hwrite,
    input  wire cache_pkg::word_t   up_hwdata,
    input  wire                up_hready,
    output cache_pkg::word_t   up_hrdata,
    output logic               up_hreadyout,
    output cache_pkg::addr_t   dn_haddr,
    output cache_pkg::htrans_t dn_htrans,
    output cache_pkg::hburst_t dn_hburst,
    output logic               dn_hwrite,
    output cache_pkg::word_t   dn_hwdata,
    input  wire cache_pkg::word_t   dn_hrdata,
    input  wire                dn_hready
);

    import cache_pkg::*;

    logic       req;
    addr_t      req_addr;
    logic       req_write;
    word_t      req_wdata;
    logic       hit;
    logic       tag_set;
    logic       tag_clear;
    logic       fill_start;
    logic       write_start;
    logic       beat_valid;
    logic [1:0] beat_word;
    word_t      beat_data;
    logic       done;

    ahb_req_capture u_capture (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .hsel          (up_hsel),
        .haddr         (up_haddr),
        .htrans        (up_htrans),
        .hwrite        (up_hwrite),
        .hwdata        (up_hwdata),
        .hready        (up_hready),
        .req           (req),
        .req_addr      (req_addr),
        .req_write     (req_write),
        .req_wdata     (req_wdata)
    );

    cache_tag_array #(
        .CACHE_SIZE (CACHE_SIZE)
    ) u_tags (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .lookup_addr   (req_addr),
        .tag_set       (tag_set),
        .tag_clear     (tag_clear),
        .hit           (hit)
    );

    cache_data_array #(
        .CACHE_SIZE (CACHE_SIZE)
    ) u_data (
        .upstream_intf (upstream_intf),
        .lookup_addr   (req_addr),
        .beat_valid    (beat_valid),
        .beat_word     (beat_word),
        .beat_data     (beat_data),
        .rdata         (up_hrdata)
    );

    line_fill_master u_master (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .fill_start    (fill_start),
        .write_start   (write_start),
        .addr          (req_addr),
        .wdata         (req_wdata),
        .hrdata        (dn_hrdata),
        .hready        (dn_hready),
        .haddr         (dn_haddr),
        .htrans        (dn_htrans),
        .hburst        (dn_hburst),
        .hwrite        (dn_hwrite),
        .hwdata        (dn_hwdata),
        .beat_valid    (beat_valid),
        .beat_word     (beat_word),
        .beat_data     (beat_data),
        .done          (done)
    );

    cache_ctrl u_ctrl (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .req           (req),
        .req_write     (req_write),
        .hit           (hit),
        .done          (done),
        .fill_start    (fill_start),
        .write_start   (write_start),
        .tag_set       (tag_set),
        .tag_clear     (tag_clear),
        .hreadyout     (up_hreadyout)
    );

endmodule

`default_nettype wire

// ==== hw/ahb_req_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module ahb_req_capture (
    input  wire                upstream_intf,
    input  wire                rst_n,
    input  wire                hsel,
    input  wire cache_pkg::addr_t   haddr,
    input  wire cache_pkg::htrans_t htrans,
    input  wire                hwrite,
    input  wire cache_pkg::word_t   hwdata,
    input  wire                hready,
    output logic               req,
    output cache_pkg::addr_t   req_addr,
    output logic               req_write,
    output cache_pkg::word_t   req_wdata
);

    import cache_pkg::*;

    logic accept;

    // only NONSEQ and SEQ carry a transfer
    assign accept = hsel && hready && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            req       <= 1'b0;
            req_addr  <= '0;
            req_write <= 1'b0;
        end else begin
            req <= accept;
            if (accept) begin
                req_addr  <= haddr;
                req_write <= hwrite;
            end
        end
    end

    // write data follows its address by one cycle
    always_ff @(posedge upstream_intf) begin
        if (req && req_write) begin
            req_wdata <= hwdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire  upstream_intf,
    input  wire  rst_n,
    input  wire  req,
    input  wire  req_write,
    input  wire  hit,
    input  wire  done,
    output logic fill_start,
    output logic write_start,
    output logic tag_set,
    output logic tag_clear,
    output logic hreadyout
);

    import cache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state;
    ctrl_state_t state_next;

    // lookup happens in the cycle the registered request appears
    assign state = (state_q == IDLE && req) ? LOOKUP : state_q;

    always_comb begin
        state_next  = state_q;
        fill_start  = 1'b0;
        write_start = 1'b0;
        tag_set     = 1'b0;
        tag_clear   = 1'b0;
        hreadyout   = 1'b1;
        case (state)
            IDLE: begin
                state_next = IDLE;
            end
            LOOKUP: begin
                if (req_write) begin
                    // write-through and a hit drops the line
                    write_start = 1'b1;
                    tag_clear   = hit;
                    hreadyout   = 1'b0;
                    state_next  = WRITE;
                end else if (!hit) begin
                    fill_start = 1'b1;
                    hreadyout  = 1'b0;
                    state_next = FILL;
                end else begin
                    state_next = IDLE;
                end
            end
            FILL: begin
                hreadyout = 1'b0;
                if (done) begin
                    tag_set    = 1'b1;
                    state_next = IDLE;
                end
            end
            WRITE: begin
                hreadyout = 1'b0;
                if (done) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_next;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cache_data_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_data_array #(
    parameter int CACHE_SIZE = 8192
) (
    input  wire              upstream_intf,
    input  wire cache_pkg::addr_t lookup_addr,
    input  wire              beat_valid,
    input  wire [1:0]        beat_word,
    input  wire cache_pkg::word_t beat_data,
    output cache_pkg::word_t rdata
);

    import cache_pkg::*;

    localparam int LINES    = CACHE_SIZE / (WORDS_PER_LINE * 4);
    localparam int OFFSET_W = $clog2(WORDS_PER_LINE) + 2;
    localparam int INDEX_W  = $clog2(LINES);
    localparam int WORD_W   = $bits(word_t);

    typedef logic [INDEX_W-1:0] index_t;

    line_t  lines [LINES];
    index_t index;

    assign index = lookup_addr[OFFSET_W +: INDEX_W];

    // one word of the line per fill beat
    always_ff @(posedge upstream_intf) begin
        if (beat_valid) begin
            lines[index][beat_word*WORD_W +: WORD_W] <= beat_data;
        end
    end

    assign rdata = lines[index][lookup_addr[3:2]*WORD_W +: WORD_W];

endmodule

`default_nettype wire

// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int WORDS_PER_LINE = 4;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;
    typedef logic [1:0] htrans_t;
    typedef logic [2:0] hburst_t;

    // AHB transfer codes
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;
    localparam htrans_t HTRANS_SEQ    = 2'b11;

    // AHB burst codes
    localparam hburst_t HBURST_SINGLE = 3'b000;
    localparam hburst_t HBURST_WRAP4  = 3'b010;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        FILL,
        WRITE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/cache_tag_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array #(
    parameter int CACHE_SIZE = 8192
) (
    input  wire              upstream_intf,
    input  wire              rst_n,
    input  wire cache_pkg::addr_t lookup_addr,
    input  wire              tag_set,
    input  wire              tag_clear,
    output logic             hit
);

    import cache_pkg::*;

    localparam int LINES    = CACHE_SIZE / (WORDS_PER_LINE * 4);
    localparam int OFFSET_W = $clog2(WORDS_PER_LINE) + 2;
    localparam int INDEX_W  = $clog2(LINES);
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    logic [LINES-1:0] valid;
    tag_t             tags [LINES];
    index_t           index;
    tag_t             tag;

    assign index = lookup_addr[OFFSET_W +: INDEX_W];
    assign tag   = lookup_addr[31 -: TAG_W];
    assign hit   = valid[index] && (tags[index] == tag);

    // reset is the only flush
    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (tag_set) begin
            valid[index] <= 1'b1;
        end else if (tag_clear) begin
            valid[index] <= 1'b0;
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (tag_set) begin
            tags[index] <= tag;
        end
    end

endmodule

`default_nettype wire

// ==== hw/line_fill_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_fill_master (
    input  wire                upstream_intf,
    input  wire                rst_n,
    input  wire                fill_start,
    input  wire                write_start,
    input  wire cache_pkg::addr_t   addr,
    input  wire cache_pkg::word_t   wdata,
    input  wire cache_pkg::word_t   hrdata,
    input  wire                hready,
    output cache_pkg::addr_t   haddr,
    output cache_pkg::htrans_t htrans,
    output cache_pkg::hburst_t hburst,
    output logic               hwrite,
    output cache_pkg::word_t   hwdata,
    output logic               beat_valid,
    output logic [1:0]         beat_word,
    output cache_pkg::word_t   beat_data,
    output logic               done
);

    import cache_pkg::*;

    // address phases still to issue after the current one
    logic [1:0] beats_left;
    logic       aph_accept;
    logic       dph_valid;
    logic       dph_write;
    logic       dph_last;
    logic [1:0] dph_word;

    assign aph_accept = hready && (htrans != HTRANS_IDLE);

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            haddr      <= '0;
            htrans     <= HTRANS_IDLE;
            hburst     <= HBURST_SINGLE;
            hwrite     <= 1'b0;
            beats_left <= '0;
        end else if (fill_start) begin
            // critical word first
            haddr      <= {addr[31:2], 2'b00};
            htrans     <= HTRANS_NONSEQ;
            hburst     <= HBURST_WRAP4;
            hwrite     <= 1'b0;
            beats_left <= 2'(WORDS_PER_LINE - 1);
        end else if (write_start) begin
            haddr      <= {addr[31:2], 2'b00};
            htrans     <= HTRANS_NONSEQ;
            hburst     <= HBURST_SINGLE;
            hwrite     <= 1'b1;
            beats_left <= '0;
        end else if (aph_accept) begin
            if (beats_left != 2'd0) begin
                // wrap inside the 16-byte line
                haddr[3:2] <= haddr[3:2] + 2'd1;
                htrans     <= HTRANS_SEQ;
                beats_left <= beats_left - 2'd1;
            end else begin
                htrans <= HTRANS_IDLE;
            end
        end
    end

    // data phase runs one beat behind the address phase
    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            dph_valid <= 1'b0;
            dph_write <= 1'b0;
            dph_last  <= 1'b0;
            dph_word  <= '0;
        end else if (hready) begin
            dph_valid <= aph_accept;
            if (aph_accept) begin
                dph_write <= hwrite;
                dph_last  <= (beats_left == 2'd0);
                dph_word  <= haddr[3:2];
            end
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (aph_accept && hwrite) begin
            hwdata <= wdata;
        end
    end

    assign beat_valid = dph_valid && hready && !dph_write;
    assign beat_word  = dph_word;
    assign beat_data  = hrdata;
    assign done       = dph_valid && hready && dph_last;

endmodule

`default_nettype wire
